//--- logic/lc3Pkg.sv
`default_nettype none

package lc3Pkg;

	// standard LC-3 opcode encodings.
	typedef enum logic [3:0] {
		OpBr   = 4'b0000,
		OpAdd  = 4'b0001,
		OpLd   = 4'b0010,
		OpSt   = 4'b0011,
		OpJsr  = 4'b0100,
		OpAnd  = 4'b0101,
		OpLdr  = 4'b0110,
		OpStr  = 4'b0111,
		OpRti  = 4'b1000,
		OpNot  = 4'b1001,
		OpLdi  = 4'b1010,
		OpSti  = 4'b1011,
		OpJmp  = 4'b1100,
		OpRes  = 4'b1101,
		OpLea  = 4'b1110,
		OpTrap = 4'b1111
	} opcodeT;

	typedef enum logic [1:0] {
		AluAdd,
		AluAnd,
		AluNot,
		AluPass
	} aluOpT;

	typedef enum logic {
		AddrPcRel,
		AddrBase
	} addrModeT;

	typedef enum logic [1:0] {
		StIdle,
		StExec,
		StDone
	} ctrlStateT;

	// byte addresses of the read map.
	localparam logic [5:0] RegAddrBase = 6'h00; // R0..R7 at 0x00..0x1C.
	localparam logic [5:0] PcAddr      = 6'h20;
	localparam logic [5:0] CcAddr      = 6'h24;

	localparam logic [5:0] InstrAddr   = 6'h00; // write map.

	localparam logic [1:0] RespOkay    = 2'd0;
	localparam logic [1:0] RespSlvErr  = 2'd2;

endpackage

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`timescale 1ns/1ps

module regFile (
	input  logic        Clk,
	input  logic        reset,
	input  logic        ldReg,
	input  logic [2:0]  drSel,
	input  logic [15:0] bus,
	input  logic [2:0]  sr1Sel,
	input  logic [2:0]  sr2Sel,
	output logic [15:0] sr1Out,
	output logic [15:0] sr2Out
);

	logic [7:0][15:0] regs;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= 16'h0;
			end
		end
		else if (ldReg)
		begin
			regs[drSel] <= bus;
		end
	end

	// both read ports are combinational.
	assign sr1Out = regs[sr1Sel];
	assign sr2Out = regs[sr2Sel]; // shared with host reads while idle.

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
`default_nettype none
`timescale 1ns/1ps

module aluUnit (
	input  logic          [15:0] srcA,
	input  logic          [15:0] srcB,
	input  logic          [4:0]  imm5,
	input  logic                 useImm,
	input  lc3Pkg::aluOpT        aluOp,
	output logic          [15:0] result
);

	logic [15:0] immExt;
	logic [15:0] opB;

	assign immExt = {{11{imm5[4]}}, imm5};
	assign opB = useImm ? immExt : srcB;

	always_comb
	begin
		case (aluOp)
			lc3Pkg::AluAdd:
			begin
				result = srcA + opB;
			end
			lc3Pkg::AluAnd:
			begin
				result = srcA & opB;
			end
			lc3Pkg::AluNot:
			begin
				result = ~srcA;
			end
			default:
			begin
				result = srcA; // pass.
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/addressUnit.sv
`default_nettype none
`timescale 1ns/1ps

module addressUnit (
	input  logic             [15:0] pc,
	input  logic             [15:0] base,
	input  logic             [8:0]  offset9,
	input  lc3Pkg::addrModeT        addrMode,
	output logic             [15:0] target
);

	logic [15:0] offExt;
	logic [15:0] pcInc;
	logic [15:0] pcRel;

	// offsets are relative to the already incremented PC.
	assign offExt = {{7{offset9[8]}}, offset9};
	assign pcInc  = pc + 16'd1;
	assign pcRel  = pcInc + offExt;

	always_comb
	begin
		if (addrMode == lc3Pkg::AddrBase)
		begin
			target = base; // JMP.
		end
		else
		begin
			target = pcRel;
		end
	end

endmodule

`default_nettype wire

//--- logic/execControl.sv
`default_nettype none
`timescale 1ns/1ps

module execControl #(
	parameter logic [15:0] ResetPc = 16'h3000
) (
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    instrValid,
	input  logic             [15:0] instr,
	input  logic             [15:0] aluResult,
	input  logic             [15:0] target,
	input  logic             [2:0]  hostRegSel,
	output logic             [2:0]  sr1Sel,
	output logic             [2:0]  sr2Sel,
	output logic                    useImm,
	output logic             [4:0]  imm5,
	output logic             [8:0]  offset9,
	output lc3Pkg::aluOpT           aluOp,
	output lc3Pkg::addrModeT        addrMode,
	output logic                    ldReg,
	output logic             [2:0]  drSel,
	output logic             [15:0] bus,
	output logic             [15:0] pc,
	output logic             [2:0]  nzp,
	output logic                    busy,
	output logic                    done,
	output logic                    illegal
);

	lc3Pkg::ctrlStateT state;
	lc3Pkg::opcodeT    opcode;
	logic [15:0] ir;
	logic        supported;
	logic        writesReg;
	logic        ben;
	logic        takeTarget;
	logic [15:0] nextPc;
	logic [2:0]  newNzp;

	assign opcode  = lc3Pkg::opcodeT'(ir[15:12]);
	assign drSel   = ir[11:9];
	assign sr1Sel  = ir[8:6]; // also the JMP base register.
	assign useImm  = ir[5];
	assign imm5    = ir[4:0];
	assign offset9 = ir[8:0];

	// the host borrows the second read port while idle.
	assign sr2Sel = (state == lc3Pkg::StIdle) ? hostRegSel : ir[2:0];

	always_comb
	begin
		supported = 1'b0;
		writesReg = 1'b0;
		aluOp     = lc3Pkg::AluPass;
		addrMode  = lc3Pkg::AddrPcRel;
		case (opcode)
			lc3Pkg::OpAdd:
			begin
				supported = 1'b1;
				writesReg = 1'b1;
				aluOp     = lc3Pkg::AluAdd;
			end
			lc3Pkg::OpAnd:
			begin
				supported = 1'b1;
				writesReg = 1'b1;
				aluOp     = lc3Pkg::AluAnd;
			end
			lc3Pkg::OpNot:
			begin
				supported = 1'b1;
				writesReg = 1'b1;
				aluOp     = lc3Pkg::AluNot;
			end
			lc3Pkg::OpLea:
			begin
				supported = 1'b1;
				writesReg = 1'b1;
			end
			lc3Pkg::OpBr:  supported = 1'b1;
			lc3Pkg::OpJmp:
			begin
				supported = 1'b1;
				addrMode  = lc3Pkg::AddrBase;
			end
			default: ; // memory, JSR, TRAP, RTI and reserved.
		endcase
	end

	// branch enable means any selected code is currently set.
	assign ben        = |(ir[11:9] & nzp);
	assign takeTarget = ((opcode == lc3Pkg::OpBr) && ben) || (opcode == lc3Pkg::OpJmp);
	assign nextPc     = takeTarget ? target : pc + 16'd1;

	assign bus    = (opcode == lc3Pkg::OpLea) ? target : aluResult;
	assign newNzp = {bus[15], (bus == 16'h0), (!bus[15] && (bus != 16'h0))};

	assign ldReg   = (state == lc3Pkg::StExec) && writesReg;
	assign busy    = (state != lc3Pkg::StIdle);
	assign done    = (state == lc3Pkg::StDone);
	assign illegal = done && !supported;

	always_ff @(posedge Clk)
	begin
		if (reset)
			state <= lc3Pkg::StIdle;
		else
		begin
			case (state)
				lc3Pkg::StIdle: if (instrValid) state <= lc3Pkg::StExec;
				lc3Pkg::StExec: state <= lc3Pkg::StDone;
				default:        state <= lc3Pkg::StIdle;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (instrValid && (state == lc3Pkg::StIdle))
			ir <= instr;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			pc  <= ResetPc;
			nzp <= 3'b010;
		end
		else
		begin
			if ((state == lc3Pkg::StExec) && supported)
				pc <= nextPc;
			if (ldReg)
				nzp <= newNzp;
		end
	end

endmodule

`default_nettype wire

//--- logic/axiLiteHost.sv
`default_nettype none
`timescale 1ns/1ps

module axiLiteHost (
	input  logic        Clk,
	input  logic        reset,
	input  logic [5:0]  AWADDR,
	input  logic        AWVALID,
	output logic        AWREADY,
	input  logic [31:0] WDATA,
	input  logic [3:0]  WSTRB,
	input  logic        WVALID,
	output logic        WREADY,
	output logic [1:0]  BRESP,
	output logic        BVALID,
	input  logic        BREADY,
	input  logic [5:0]  ARADDR,
	input  logic        ARVALID,
	output logic        ARREADY,
	output logic [31:0] RDATA,
	output logic [1:0]  RRESP,
	output logic        RVALID,
	input  logic        RREADY,
	output logic        instrValid,
	output logic [15:0] instr,
	input  logic        busy,
	input  logic        done,
	input  logic        illegal,
	output logic [2:0]  hostRegSel,
	input  logic [15:0] regData,
	input  logic [15:0] pc,
	input  logic [2:0]  nzp
);

	logic        wrAccept;
	logic        rdAccept;
	logic        wrPending; // accepted, response not yet raised.
	logic        wrBad;
	logic        wrRespNow;
	logic        rdPending;
	logic [31:0] rdWord;
	logic [1:0]  rdResp;

	assign wrAccept   = AWVALID && AWREADY && WVALID && WREADY;
	assign rdAccept   = ARVALID && ARREADY;
	assign wrRespNow  = wrPending && (wrBad || done);
	assign hostRegSel = ARADDR[4:2];

	always_comb
	begin
		rdWord = 32'h0;
		rdResp = lc3Pkg::RespOkay;
		if ((ARADDR & ~6'h1C) == lc3Pkg::RegAddrBase)
			rdWord = {16'h0, regData};
		else if (ARADDR == lc3Pkg::PcAddr)
			rdWord = {16'h0, pc};
		else if (ARADDR == lc3Pkg::CcAddr)
			rdWord = {29'h0, nzp};
		else
			rdResp = lc3Pkg::RespSlvErr;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			AWREADY    <= 1'b0;
			WREADY     <= 1'b0;
			BVALID     <= 1'b0;
			instrValid <= 1'b0;
			wrPending  <= 1'b0;
			wrBad      <= 1'b0;
		end
		else
		begin
			instrValid <= 1'b0;
			if (wrAccept)
			begin
				AWREADY   <= 1'b0;
				WREADY    <= 1'b0;
				wrPending <= 1'b1;
				if (AWADDR == lc3Pkg::InstrAddr)
					instrValid <= 1'b1;
				else
					wrBad <= 1'b1;
			end
			else if (AWVALID && WVALID && !AWREADY && !wrPending && !BVALID && !busy)
			begin
				AWREADY <= 1'b1;
				WREADY  <= 1'b1;
			end

			if (wrRespNow)
			begin
				BVALID    <= 1'b1;
				wrPending <= 1'b0;
				wrBad     <= 1'b0;
			end
			else if (BVALID && BREADY)
				BVALID <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (wrAccept)
			instr <= WDATA[15:0];
		if (wrRespNow)
			BRESP <= (wrBad || illegal) ? lc3Pkg::RespSlvErr : lc3Pkg::RespOkay;
	end

	// reads wait while an instruction is in flight, it owns the sr2 port.
	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			ARREADY   <= 1'b0;
			RVALID    <= 1'b0;
			rdPending <= 1'b0;
		end
		else
		begin
			if (rdAccept)
			begin
				ARREADY   <= 1'b0;
				rdPending <= 1'b1;
			end
			else if (ARVALID && !ARREADY && !rdPending && !RVALID && !busy && !wrPending)
				ARREADY <= 1'b1;

			if (rdPending)
			begin
				RVALID    <= 1'b1;
				rdPending <= 1'b0;
			end
			else if (RVALID && RREADY)
				RVALID <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rdAccept)
		begin
			RDATA <= rdWord;
			RRESP <= rdResp;
		end
	end

endmodule

`default_nettype wire

//--- logic/lc3Top.sv
`default_nettype none
`timescale 1ns/1ps

module lc3Top #(
	parameter logic [15:0] ResetPc = 16'h3000
) (
	input  logic        Clk,
	input  logic        reset,
	input  logic [5:0]  AWADDR,
	input  logic        AWVALID,
	output logic        AWREADY,
	input  logic [31:0] WDATA,
	input  logic [3:0]  WSTRB,
	input  logic        WVALID,
	output logic        WREADY,
	output logic [1:0]  BRESP,
	output logic        BVALID,
	input  logic        BREADY,
	input  logic [5:0]  ARADDR,
	input  logic        ARVALID,
	output logic        ARREADY,
	output logic [31:0] RDATA,
	output logic [1:0]  RRESP,
	output logic        RVALID,
	input  logic        RREADY
);

	logic             instrValid;
	logic [15:0]      instr;
	logic             busy;
	logic             done;
	logic             illegal;
	logic [2:0]       hostRegSel;
	logic [15:0]      pc;
	logic [2:0]       nzp;
	logic [2:0]       sr1Sel;
	logic [2:0]       sr2Sel;
	logic [15:0]      sr1Out;
	logic [15:0]      sr2Out;
	logic             useImm;
	logic [4:0]       imm5;
	logic [8:0]       offset9;
	lc3Pkg::aluOpT    aluOp;
	lc3Pkg::addrModeT addrMode;
	logic             ldReg;
	logic [2:0]       drSel;
	logic [15:0]      bus;
	logic [15:0]      aluResult;
	logic [15:0]      target;

	axiLiteHost host (
		.Clk, .reset,
		.AWADDR, .AWVALID, .AWREADY,
		.WDATA, .WSTRB, .WVALID, .WREADY,
		.BRESP, .BVALID, .BREADY,
		.ARADDR, .ARVALID, .ARREADY,
		.RDATA, .RRESP, .RVALID, .RREADY,
		.instrValid, .instr, .busy, .done, .illegal,
		.hostRegSel, .regData(sr2Out), .pc, .nzp
	);

	execControl #(.ResetPc(ResetPc)) ctrl (
		.Clk, .reset, .instrValid, .instr, .aluResult, .target, .hostRegSel,
		.sr1Sel, .sr2Sel, .useImm, .imm5, .offset9, .aluOp, .addrMode,
		.ldReg, .drSel, .bus, .pc, .nzp, .busy, .done, .illegal
	);

	regFile regs (
		.Clk, .reset, .ldReg, .drSel, .bus,
		.sr1Sel, .sr2Sel, .sr1Out, .sr2Out
	);

	// both units see the same decoded instruction.
	aluUnit alu (
		.srcA(sr1Out), .srcB(sr2Out), .imm5, .useImm, .aluOp, .result(aluResult)
	);

	addressUnit addrUnit (
		.pc, .base(sr1Out), .offset9, .addrMode, .target
	);

endmodule

`default_nettype wire

//--- dv/lc3_props.sv
`default_nettype none
`timescale 1ns/1ps

module lc3Props (
	input logic        Clk,
	input logic        reset,
	input logic        AWREADY,
	input logic        WREADY,
	input logic        ARREADY,
	input logic [1:0]  BRESP,
	input logic        BVALID,
	input logic        BREADY,
	input logic [31:0] RDATA,
	input logic [1:0]  RRESP,
	input logic        RVALID,
	input logic        RREADY
);

	resetQuiet: assert property (@(posedge Clk)
		reset |=> (!AWREADY && !WREADY && !ARREADY && !BVALID && !RVALID))
		else $error("handshake outputs not low after reset.");

	bHold: assert property (@(posedge Clk) disable iff (reset)
		(BVALID && !BREADY) |=> (BVALID && $stable(BRESP)))
		else $error("write response dropped or changed before BREADY.");

	rHold: assert property (@(posedge Clk) disable iff (reset)
		(RVALID && !RREADY) |=> (RVALID && $stable(RDATA) && $stable(RRESP)))
		else $error("read response dropped or changed before RREADY.");

	// no write is accepted while a response waits.
	noWriteWhilePending: assert property (@(posedge Clk) disable iff (reset)
		BVALID |-> !AWREADY)
		else $error("AWREADY high with BVALID pending.");

endmodule

bind axiLiteHost lc3Props props (
	.Clk(Clk), .reset(reset),
	.AWREADY(AWREADY), .WREADY(WREADY), .ARREADY(ARREADY),
	.BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
	.RDATA(RDATA), .RRESP(RRESP), .RVALID(RVALID), .RREADY(RREADY)
);

`default_nettype wire

//--- dv/lc3Tb.sv
`default_nettype none
`timescale 1ns/1ps

module lc3Tb;

	localparam logic [15:0] StartPc = 16'h3000;
	localparam int NumAlu  = 60;
	localparam int NumFlow = 50;
	// about 100 cycles per instruction covers the write and ten read-backs with stalls.
	localparam int MaxCycles = (NumAlu + NumFlow + 10) * 100;

	logic        Clk;
	logic        reset;
	logic [5:0]  AWADDR;
	logic        AWVALID;
	logic        AWREADY;
	logic [31:0] WDATA;
	logic [3:0]  WSTRB;
	logic        WVALID;
	logic        WREADY;
	logic [1:0]  BRESP;
	logic        BVALID;
	logic        BREADY;
	logic [5:0]  ARADDR;
	logic        ARVALID;
	logic        ARREADY;
	logic [31:0] RDATA;
	logic [1:0]  RRESP;
	logic        RVALID;
	logic        RREADY;

	logic [15:0] mReg [8]; // model state.
	logic [15:0] mPc;
	logic [2:0]  mNzp;
	logic [31:0] seed = 32'h5438_ad8a;
	int          maxStall = 3;
	int          cycleCount = 0;
	string       nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];

	lc3Top #(.ResetPc(StartPc)) UUT (
		.Clk, .reset,
		.AWADDR, .AWVALID, .AWREADY,
		.WDATA, .WSTRB, .WVALID, .WREADY,
		.BRESP, .BVALID, .BREADY,
		.ARADDR, .ARVALID, .ARREADY,
		.RDATA, .RRESP, .RVALID, .RREADY
	);

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	function automatic logic [31:0] nextRand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic int pickStall();
		logic [31:0] r;
		r = nextRand();
		if (r[3])
			return int'(r[7:4]) % (maxStall + 1);
		else
			return 0;
	endfunction

	function automatic logic [2:0] nzpOf(input logic [15:0] v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0)
			return 3'b010;
		else
			return 3'b001;
	endfunction

	// applies one instruction to the model, returns the expected write response.
	function automatic logic [1:0] refExec(input logic [15:0] ins);
		lc3Pkg::opcodeT op;
		logic [15:0]    opB;
		logic [15:0]    pcRel;
		logic [15:0]    res;
		logic           wr;
		op    = lc3Pkg::opcodeT'(ins[15:12]);
		opB   = ins[5] ? {{11{ins[4]}}, ins[4:0]} : mReg[ins[2:0]];
		pcRel = mPc + 16'd1 + {{7{ins[8]}}, ins[8:0]};
		res   = 16'h0;
		wr    = 1'b1;
		case (op)
			lc3Pkg::OpAdd: res = mReg[ins[8:6]] + opB;
			lc3Pkg::OpAnd: res = mReg[ins[8:6]] & opB;
			lc3Pkg::OpNot: res = ~mReg[ins[8:6]];
			lc3Pkg::OpLea: res = pcRel;
			lc3Pkg::OpBr:  wr = 1'b0;
			lc3Pkg::OpJmp: wr = 1'b0;
			default:       return lc3Pkg::RespSlvErr; // state stays as it is.
		endcase
		if (wr)
		begin
			mReg[ins[11:9]] = res;
			mNzp = nzpOf(res);
		end
		if (op == lc3Pkg::OpJmp)
			mPc = mReg[ins[8:6]];
		else if ((op == lc3Pkg::OpBr) && ((ins[11:9] & mNzp) != 3'b000))
			mPc = pcRel;
		else
			mPc = mPc + 16'd1;
		return lc3Pkg::RespOkay;
	endfunction

	function automatic logic [15:0] randAlu();
		logic [31:0] r;
		r = nextRand();
		if (r[1:0] == 2'd2)
			return {lc3Pkg::OpNot, r[4:2], r[7:5], 6'h3F};
		else if (r[1:0] == 2'd1)
			return {lc3Pkg::OpAnd, r[4:2], r[7:5], r[8], r[8] ? r[13:9] : {2'b00, r[11:9]}};
		else
			return {lc3Pkg::OpAdd, r[4:2], r[7:5], r[8], r[8] ? r[13:9] : {2'b00, r[11:9]}};
	endfunction

	function automatic logic [15:0] randFlow();
		logic [31:0] r;
		r = nextRand();
		case (r[2:0])
			3'd2:             return {lc3Pkg::OpLea, r[5:3], r[14:6]};
			3'd3, 3'd4, 3'd5: return {lc3Pkg::OpBr, r[5:3], r[14:6]}; // mask in r[5:3].
			3'd6:             return {lc3Pkg::OpJmp, 3'b000, r[5:3], 6'h00};
			default:          return randAlu();
		endcase
	endfunction

	task automatic postCheck(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		nameQ.push_back(name);
		expQ.push_back(expVal);
		actQ.push_back(actVal);
	endtask

	task automatic writeIssue(input logic [5:0] addr, input logic [15:0] data);
		int lat;
		AWADDR  = addr;
		WDATA   = {16'h0, data};
		AWVALID = 1'b1;
		WVALID  = 1'b1;
		while (!(AWREADY && WREADY))
		begin
			@(posedge Clk);
			#2;
		end
		@(posedge Clk); // handshake edge.
		#2;
		AWVALID = 1'b0;
		WVALID  = 1'b0;
		lat = 0;
		while (!BVALID && (lat < 20))
		begin
			@(posedge Clk);
			#2;
			lat++;
		end
		// instructions go through exec and done before the response.
		postCheck("BVALID latency", (addr == lc3Pkg::InstrAddr) ? 32'd3 : 32'd1, lat);
	endtask

	task automatic writeResp(input logic [1:0] expResp, input int stall);
		logic [1:0] firstResp;
		firstResp = BRESP;
		postCheck("BRESP", {30'h0, expResp}, {30'h0, BRESP});
		repeat (stall)
		begin
			@(posedge Clk);
			#2;
			postCheck("BVALID while BREADY low", 32'd1, {31'h0, BVALID});
			postCheck("BRESP while BREADY low", {30'h0, firstResp}, {30'h0, BRESP});
			postCheck("AWREADY while response pending", 32'd0, {31'h0, AWREADY});
			postCheck("WREADY while response pending", 32'd0, {31'h0, WREADY});
		end
		BREADY = 1'b1;
		@(posedge Clk);
		#2;
		BREADY = 1'b0;
	endtask

	task automatic readReg(input logic [5:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp);
		logic [31:0] firstData;
		int          stall;
		stall   = pickStall();
		ARADDR  = addr;
		ARVALID = 1'b1;
		while (!ARREADY)
		begin
			@(posedge Clk);
			#2;
		end
		@(posedge Clk);
		#2;
		ARVALID = 1'b0;
		while (!RVALID)
		begin
			@(posedge Clk);
			#2;
		end
		firstData = RDATA;
		postCheck($sformatf("RDATA at 0x%02h", addr), expData, RDATA);
		postCheck($sformatf("RRESP at 0x%02h", addr), {30'h0, expResp}, {30'h0, RRESP});
		repeat (stall)
		begin
			@(posedge Clk);
			#2;
			postCheck("RVALID while RREADY low", 32'd1, {31'h0, RVALID});
			postCheck("RDATA while RREADY low", firstData, RDATA);
		end
		RREADY = 1'b1;
		@(posedge Clk);
		#2;
		RREADY = 1'b0;
	endtask

	task automatic checkAll();
		for (int i = 0; i < 8; i++)
			readReg(lc3Pkg::RegAddrBase + 6'(i * 4), {16'h0, mReg[i]}, lc3Pkg::RespOkay);
		readReg(lc3Pkg::PcAddr, {16'h0, mPc}, lc3Pkg::RespOkay);
		readReg(lc3Pkg::CcAddr, {29'h0, mNzp}, lc3Pkg::RespOkay);
	endtask

	task automatic runInstr(input logic [15:0] ins);
		logic [1:0] expResp;
		expResp = refExec(ins);
		writeIssue(lc3Pkg::InstrAddr, ins);
		writeResp(expResp, pickStall());
		checkAll();
	endtask

	always @(posedge Clk)
	begin : compareResults
		string       name;
		logic [31:0] expVal;
		logic [31:0] actVal;
		while (actQ.size() > 0)
		begin
			name   = nameQ.pop_front();
			expVal = expQ.pop_front();
			actVal = actQ.pop_front();
			assert (actVal == expVal)
			else
			begin
				$display("MISMATCH at %0d ns: %s expected %h, actual %h",
					$time, name, expVal, actVal);
				$display("Test failed");
				$fatal(1, "first mismatch ends the run");
			end
		end
	end

	always @(posedge Clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= MaxCycles)
		begin
			$display("Timeout after %0d cycles, the test hung on a handshake", cycleCount);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [1:0]  expResp;
		logic [15:0] insA;
		logic [15:0] insB;
		reset   = 1'b1;
		AWADDR  = 6'h0;
		AWVALID = 1'b0;
		WDATA   = 32'h0;
		WSTRB   = 4'hF;
		WVALID  = 1'b0;
		BREADY  = 1'b0;
		ARADDR  = 6'h0;
		ARVALID = 1'b0;
		RREADY  = 1'b0;
		for (int i = 0; i < 8; i++)
			mReg[i] = 16'h0;
		mPc  = StartPc;
		mNzp = 3'b010;
		repeat (3) @(posedge Clk);
		#2;
		reset = 1'b0;

		checkAll();
		for (int n = 0; n < NumAlu; n++)
			runInstr(randAlu());
		for (int n = 0; n < NumFlow; n++)
			runInstr(randFlow());

		// unsupported opcodes and bad addresses.
		runInstr({lc3Pkg::OpLd, 12'h123});
		runInstr({lc3Pkg::OpTrap, 12'h025});
		runInstr({lc3Pkg::OpRti, 12'h000});
		writeIssue(6'h04, {lc3Pkg::OpAdd, 12'h021});
		writeResp(lc3Pkg::RespSlvErr, 0);
		checkAll();
		readReg(6'h28, 32'h0, lc3Pkg::RespSlvErr);
		readReg(6'h3C, 32'h0, lc3Pkg::RespSlvErr);
		readReg(6'h22, 32'h0, lc3Pkg::RespSlvErr);

		maxStall = 15;
		for (int n = 0; n < 4; n++)
			runInstr(randAlu());

		// second write waits behind an unaccepted response.
		insA    = randAlu();
		insB    = randFlow();
		expResp = refExec(insA);
		writeIssue(lc3Pkg::InstrAddr, insA);
		AWADDR  = lc3Pkg::InstrAddr;
		WDATA   = {16'h0, insB};
		AWVALID = 1'b1;
		WVALID  = 1'b1;
		checkAll(); // insB has not run.
		writeResp(expResp, 8);
		runInstr(insB);

		@(posedge Clk);
		#2;
		if (actQ.size() == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("%0d results were never compared", actQ.size());
			$display("Test failed");
			$fatal(1, "results left unchecked");
		end
	end

endmodule

`default_nettype wire

//--- compile.f
logic/lc3Pkg.sv
logic/regFile.sv
logic/aluUnit.sv
logic/addressUnit.sv
logic/execControl.sv
logic/axiLiteHost.sv
logic/lc3Top.sv
dv/lc3_props.sv
dv/lc3Tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the LC-3 core testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module lc3Tb -f compile.f -o lc3Sim

./obj_dir/lc3Sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
